// ==== hw/mem_pkg.sv ====
package mem_pkg;

	// Bus widths of the load/store port.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Four word-interleaved banks, 256 words each.
	localparam int BANK_COUNT = 4;
	localparam int BANK_SEL_W = 2;
	localparam int BANK_WORDS = 256;
	localparam int WORD_IDX_W = 8;

	// Scratch memory window.
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] MEM_BYTES = 32'd4096;

	localparam logic [7:0] LFSR_SEED = 8'hA5; // Any nonzero value.

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_DECERR = 2'b11
	} axi_resp_t;

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_WAIT,
		BANK_DONE
	} bank_state_t;

endpackage

// ==== hw/bank_req_if.sv ====
`timescale 1ns/1ps

interface bank_req_if import mem_pkg::*; ();

	logic valid;
	logic we;
	logic [WORD_IDX_W-1:0] index;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic ready;

	modport dec (
		output valid,
		output we,
		output index,
		output wdata,
		output wstrb,
		input ready
	);

	modport bank (
		input valid,
		input we,
		input index,
		input wdata,
		input wstrb,
		output ready
	);

endinterface

// ==== hw/bank_rsp_if.sv ====
`timescale 1ns/1ps

interface bank_rsp_if import mem_pkg::*; ();

	logic valid;
	logic [DATA_W-1:0] rdata;
	logic was_write; // Lets the merger steer the answer to R or B.
	logic ready;

	modport bank (
		output valid,
		output rdata,
		output was_write,
		input ready
	);

	modport merge (
		input valid,
		input rdata,
		input was_write,
		output ready
	);

endinterface

// ==== hw/addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode import mem_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic [ADDR_W-1:0] araddr,
	input logic [ADDR_W-1:0] awaddr,
	input logic arvalid,
	input logic awvalid,
	input logic wvalid,
	input logic [DATA_W-1:0] wdata,
	input logic [STRB_W-1:0] wstrb,
	output logic arready,
	output logic awready,
	output logic wready,
	bank_req_if.dec req [BANK_COUNT],
	output logic pend,
	output logic pend_write,
	output logic pend_err,
	output logic [BANK_SEL_W-1:0] pend_bank,
	input logic done
);

	logic accept_rd;
	logic accept_wr;
	logic accept;
	logic [ADDR_W-1:0] in_addr;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic req_active;
	logic [BANK_COUNT-1:0] bank_ready;

	function automatic logic in_window(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] offset;
		offset = addr - MEM_BASE; // Wraps high for addresses below the base.
		return offset < MEM_BYTES;
	endfunction

	// A read wins over a write arriving in the same cycle.
	assign arready = !pend;
	assign awready = !pend && !arvalid;
	assign wready = !pend && !arvalid;

	assign accept_rd = !pend && arvalid;
	assign accept_wr = !pend && !arvalid && awvalid && wvalid;
	assign accept = accept_rd || accept_wr;
	assign in_addr = accept_wr ? awaddr : araddr;

	// Bits 3..2 pick the bank.
	assign pend_bank = addr_q[BANK_SEL_W+1:2];

	for (genvar b = 0; b < BANK_COUNT; b++) begin : g_req
		assign req[b].valid = req_active && (pend_bank == BANK_SEL_W'(b));
		assign req[b].we = pend_write;
		assign req[b].index = addr_q[WORD_IDX_W+BANK_SEL_W+1:BANK_SEL_W+2];
		assign req[b].wdata = wdata_q;
		assign req[b].wstrb = wstrb_q;
		assign bank_ready[b] = req[b].ready;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pend <= 1'b0;
			pend_write <= 1'b0;
			pend_err <= 1'b0;
			req_active <= 1'b0;
		end else if (accept) begin
			pend <= 1'b1;
			pend_write <= accept_wr;
			pend_err <= !in_window(in_addr);
			req_active <= in_window(in_addr); // Unmapped: no bank sees it.
		end else begin
			if (req_active && bank_ready[pend_bank]) begin
				req_active <= 1'b0;
			end
			if (done) begin
				pend <= 1'b0;
				pend_err <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q <= in_addr;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

endmodule

// ==== hw/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank import mem_pkg::*; (
	input logic clock,
	input logic arst_n,
	bank_req_if.bank req,
	bank_rsp_if.bank rsp
);

	bank_state_t state;
	logic [1:0] wait_cnt;
	logic [7:0] lfsr;
	logic we_q;
	logic accept;
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] mem [BANK_WORDS];

	assign req.ready = (state == BANK_IDLE);
	assign accept = req.valid && req.ready;

	assign rsp.valid = (state == BANK_DONE);
	assign rsp.rdata = rdata_q;
	assign rsp.was_write = we_q;

	// Taps 8,6,5,4 give a maximal length sequence.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= BANK_IDLE;
			wait_cnt <= 2'd0;
			we_q <= 1'b0;
		end else begin
			case (state)
				BANK_IDLE: begin
					if (accept) begin
						we_q <= req.we;
						wait_cnt <= lfsr[1:0]; // Random stall of 0 to 3 cycles.
						if (lfsr[1:0] == 2'd0) begin
							state <= BANK_DONE;
						end else begin
							state <= BANK_WAIT;
						end
					end
				end
				BANK_WAIT: begin
					wait_cnt <= wait_cnt - 2'd1;
					if (wait_cnt == 2'd1) begin
						state <= BANK_DONE;
					end
				end
				BANK_DONE: begin
					if (rsp.valid && rsp.ready) begin
						state <= BANK_IDLE;
					end
				end
				default: begin
					state <= BANK_IDLE;
				end
			endcase
		end
	end

	// Storage is read and written at accept time.
	always_ff @(posedge clock) begin
		if (accept) begin
			rdata_q <= mem[req.index];
			if (req.we) begin
				for (int i = 0; i < STRB_W; i++) begin
					if (req.wstrb[i]) begin
						mem[req.index][8*i +: 8] <= req.wdata[8*i +: 8];
					end
				end
			end
		end
	end

endmodule

// ==== hw/resp_merge.sv ====
`timescale 1ns/1ps

module resp_merge import mem_pkg::*; (
	input logic clock,
	input logic arst_n,
	bank_rsp_if.merge rsp [BANK_COUNT],
	input logic pend,
	input logic pend_write,
	input logic pend_err,
	input logic [BANK_SEL_W-1:0] pend_bank,
	output logic [DATA_W-1:0] rdata,
	output axi_resp_t rresp,
	output axi_resp_t bresp,
	output logic rvalid,
	output logic bvalid,
	input logic rready,
	input logic bready,
	output logic done
);

	logic [BANK_COUNT-1:0] bank_valid;
	logic [BANK_COUNT-1:0] bank_write;
	logic [DATA_W-1:0] bank_rdata [BANK_COUNT];
	logic out_full;
	logic take_bank;
	logic take_err;
	logic take_write;
	axi_resp_t resp_q;

	assign out_full = rvalid || bvalid;

	for (genvar b = 0; b < BANK_COUNT; b++) begin : g_rsp
		assign rsp[b].ready = pend && !pend_err && !out_full
			&& (pend_bank == BANK_SEL_W'(b));
		assign bank_valid[b] = rsp[b].valid;
		assign bank_write[b] = rsp[b].was_write;
		assign bank_rdata[b] = rsp[b].rdata;
	end

	assign take_bank = pend && !pend_err && !out_full && bank_valid[pend_bank];
	assign take_err = pend && pend_err && !out_full; // No bank to wait for.
	assign take_write = pend_err ? pend_write : bank_write[pend_bank];

	assign done = (rvalid && rready) || (bvalid && bready);
	assign rresp = resp_q;
	assign bresp = resp_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else if (take_bank || take_err) begin
			rvalid <= !take_write;
			bvalid <= take_write;
		end else if (done) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end
	end

	// Held until the master's handshake.
	always_ff @(posedge clock) begin
		if (take_bank || take_err) begin
			rdata <= take_err ? '0 : bank_rdata[pend_bank];
			resp_q <= take_err ? RESP_DECERR : RESP_OKAY;
		end
	end

endmodule

// ==== hw/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic [ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic [ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [DATA_W-1:0] wdata,
	input logic [STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready
);

	logic pend;
	logic pend_write;
	logic pend_err;
	logic [BANK_SEL_W-1:0] pend_bank;
	logic done;

	bank_req_if req_if [BANK_COUNT] ();
	bank_rsp_if rsp_if [BANK_COUNT] ();

	addr_decode i_decode (
		.clock(clock),
		.arst_n(arst_n),
		.araddr(araddr),
		.awaddr(awaddr),
		.arvalid(arvalid),
		.awvalid(awvalid),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.arready(arready),
		.awready(awready),
		.wready(wready),
		.req(req_if),
		.pend(pend),
		.pend_write(pend_write),
		.pend_err(pend_err),
		.pend_bank(pend_bank),
		.done(done)
	);

	// Word-interleaved banks.
	for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
		sram_bank i_bank (
			.clock(clock),
			.arst_n(arst_n),
			.req(req_if[i]),
			.rsp(rsp_if[i])
		);
	end

	resp_merge i_merge (
		.clock(clock),
		.arst_n(arst_n),
		.rsp(rsp_if),
		.pend(pend),
		.pend_write(pend_write),
		.pend_err(pend_err),
		.pend_bank(pend_bank),
		.rdata(rdata),
		.rresp(rresp),
		.bresp(bresp),
		.rvalid(rvalid),
		.bvalid(bvalid),
		.rready(rready),
		.bready(bready),
		.done(done)
	);

endmodule

// ==== tb/mem_subsys_props.sv ====
`timescale 1ns/1ps

module mem_subsys_props import mem_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic arready,
	input logic [DATA_W-1:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready
);

	int fail_count = 0;

	// Reset clears both answer channels.
	a_reset_clears: assert property (@(posedge clock) !arst_n |=> !rvalid && !bvalid)
		else begin
			$error("rvalid or bvalid high after reset");
			fail_count++;
		end

	a_r_stable: assert property (@(posedge clock) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("R answer changed while rready was low");
			fail_count++;
		end

	a_b_stable: assert property (@(posedge clock) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("B answer changed while bready was low");
			fail_count++;
		end

	a_no_accept: assert property (@(posedge clock) disable iff (!arst_n)
		(rvalid || bvalid) |-> !arready)
		else begin
			$error("arready high while an answer is pending");
			fail_count++;
		end

endmodule

bind mem_subsys mem_subsys_props i_props (
	.clock(clock),
	.arst_n(arst_n),
	.arready(arready),
	.rdata(rdata),
	.rresp(rresp),
	.rvalid(rvalid),
	.rready(rready),
	.bresp(bresp),
	.bvalid(bvalid),
	.bready(bready)
);

// ==== tb/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb import mem_pkg::*; ();

	// Worst case per transaction is handshake, 6 cycles of latency and 6 of stall.
	localparam int TXN_COUNT = 135;
	localparam int TXN_CYCLES = 15;
	localparam int WATCHDOG_CYCLES = TXN_COUNT * TXN_CYCLES;

	logic clock;
	logic arst_n;
	logic [ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	logic [7:0] model [0:MEM_BYTES-1]; // Byte image of the scratch memory.
	logic [ADDR_W-1:0] known [32]; // Words written at least once.
	int checks;
	int errors;
	int test_errors;
	int prop_fails;

	mem_subsys i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	function automatic logic mapped(input logic [ADDR_W-1:0] addr);
		return addr >= MEM_BASE && addr < MEM_BASE + MEM_BYTES;
	endfunction

	function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
		logic [9:0] w;
		w = addr[11:2];
		return {model[{w, 2'd3}], model[{w, 2'd2}], model[{w, 2'd1}], model[{w, 2'd0}]};
	endfunction

	task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		logic [9:0] w;
		w = addr[11:2];
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i]) begin
				model[{w, 2'(i)}] = data[8*i +: 8];
			end
		end
	endtask

	// Holds the master's ready low while the answer waits.
	task automatic stall_response(input int stall, input logic is_write);
		if (is_write) begin
			bready = 1'b0;
		end else begin
			rready = 1'b0;
		end
		repeat (stall) begin
			next_cycle();
			checks++;
			assert ((is_write ? bvalid : rvalid) && !arready && !awready) else begin
				$error("FAILED at %0t ns: answer lost or request taken under back-pressure",
					$time);
				errors++;
			end
		end
		rready = 1'b1;
		bready = 1'b1;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, input int stall);
		logic [DATA_W-1:0] exp_data;
		logic [1:0] exp_resp;
		exp_data = mapped(addr) ? model_word(addr) : '0;
		exp_resp = mapped(addr) ? RESP_OKAY : RESP_DECERR;
		araddr = addr;
		arvalid = 1'b1;
		while (!arready) begin
			next_cycle();
		end
		next_cycle();
		arvalid = 1'b0;
		while (!rvalid) begin
			next_cycle();
		end
		stall_response(stall, 1'b0);
		checks++;
		assert (rdata === exp_data && rresp === exp_resp) else begin
			$error("FAILED at %0t ns: read %h gave %h resp %0d, expected %h resp %0d",
				$time, addr, rdata, rresp, exp_data, exp_resp);
			errors++;
		end
		next_cycle(); // R handshake.
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, input int stall);
		logic [1:0] exp_resp;
		exp_resp = mapped(addr) ? RESP_OKAY : RESP_DECERR;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(awready && wready)) begin
			next_cycle();
		end
		next_cycle();
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (mapped(addr)) begin
			model_write(addr, data, strb);
		end
		while (!bvalid) begin
			next_cycle();
		end
		stall_response(stall, 1'b1);
		checks++;
		assert (bresp === exp_resp) else begin
			$error("FAILED at %0t ns: write %h gave resp %0d, expected %0d",
				$time, addr, bresp, exp_resp);
			errors++;
		end
		next_cycle(); // B handshake.
	endtask

	task automatic finish_test(input string name);
		errors += i_dut.i_props.fail_count - prop_fails;
		prop_fails = i_dut.i_props.fail_count;
		$display("%s: done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		logic [ADDR_W-1:0] addr;
		void'($urandom(42));
		checks = 0;
		errors = 0;
		test_errors = 0;
		prop_fails = 0;
		arst_n = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		arst_n = 1'b1;

		next_cycle();
		checks++;
		assert (!rvalid && !bvalid && arready && awready && wready) else begin
			$error("FAILED at %0t ns: wrong valid or ready level after reset", $time);
			errors++;
		end
		finish_test("Test 1 reset state");

		// Bank index follows the loop count so every bank is hit.
		for (int i = 0; i < 32; i++) begin
			known[i] = MEM_BASE | {20'd0, 8'($urandom), 2'(i), 2'b00};
			axi_write(known[i], $urandom, 4'hF, 0);
			axi_read(known[i], 0);
		end
		finish_test("Test 2 full-word write and read");

		for (int i = 0; i < 4; i++) begin
			axi_write(known[i], 32'hA1B2_C3D4, 4'b0101, 0);
			axi_read(known[i], 0);
		end
		finish_test("Test 3 partial strobes");

		axi_read(32'h0000_1000, 0);
		axi_read(MEM_BASE + MEM_BYTES, 0);
		axi_write(known[5] + MEM_BYTES, $urandom, 4'hF, 0); // Same bank bits as known[5].
		axi_write(32'hFFFF_FFFC, $urandom, 4'hF, 0);
		axi_read(32'h7FFF_FFFC, 0);
		axi_read(known[5], 0);
		finish_test("Test 4 decode error");

		for (int i = 0; i < 8; i++) begin
			addr = known[5'($urandom)];
			axi_write(addr, $urandom, 4'($urandom), $urandom_range(6, 1));
			axi_read(addr, $urandom_range(6, 1));
		end
		axi_read(32'h0000_0040, 3);
		finish_test("Test 5 back-pressure");

		for (int i = 0; i < 40; i++) begin
			addr = known[5'($urandom)];
			if ($urandom % 2 == 0) begin
				axi_write(addr, $urandom, 4'($urandom), 0);
			end else begin
				axi_read(addr, 0);
			end
		end
		finish_test("Test 6 mixed traffic");

		$display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== mem_subsys.f ====
hw/mem_pkg.sv
hw/bank_req_if.sv
hw/bank_rsp_if.sv
hw/addr_decode.sv
hw/sram_bank.sv
hw/resp_merge.sv
hw/mem_subsys.sv
tb/mem_subsys_props.sv
tb/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mem_subsys_tb
FILELIST ?= mem_subsys.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
